/* Makefile */
# Verilator build and run of the receive sample path testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f all.f --top-module tb_rx_top \
		-Mdir $(OBJ_DIR) -o tb_rx_top
	-./$(OBJ_DIR)/tb_rx_top > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
+incdir+testbench
design/rx_pkg.sv
design/setting_reg.sv
design/decim_strobe_gen.sv
design/rx_decimator.sv
design/rx_source_select.sv
design/rx_top.sv
testbench/tb_rx_top.sv

/* design/decim_strobe_gen.sv */
// Decimation strobe generator
//   Down-counter that divides clk64 by rate+1 while enabled
//   One-cycle strobe each time the count reaches zero
//   Counter holds the rate while disabled, so a new rate applies on reload

`timescale 1ns/1ps

module decim_strobe_gen (
   input  logic             clk64,
   input  logic             rx_dsp_reset,
   input  logic             i_enable,
   input  rx_pkg::rx_rate_t i_rate,
   output logic             o_strobe
);

   import rx_pkg::*;

   rx_rate_t count;

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         count <= '0;
      end
      else if (!i_enable)
      begin
         // Preload so the first strobe lands rate+1 cycles after enable
         count <= i_rate;
      end
      else if (count == '0)
      begin
         count <= i_rate;
      end
      else
      begin
         count <= count - 1'b1;
      end
   end

   // Low whenever disabled
   assign o_strobe = i_enable && (count == '0);

endmodule

/* design/rx_decimator.sv */
// Integrate-and-dump decimator for one I/Q channel
//   Two 16-bit accumulators sum I and Q on every enabled cycle
//   On the decimator strobe the sum, including that cycle's sample, is dumped
//   Boxcar decimation by rate+1 with no gain correction, sums wrap to 16 bits
//   Valid pulse follows the strobe by one cycle

`timescale 1ns/1ps

module rx_decimator (
   input  logic               clk64,
   input  logic               rx_dsp_reset,
   input  logic               i_enable,
   input  logic               i_strobe,
   input  rx_pkg::iq_sample_t i_sample,
   output rx_pkg::iq_sample_t o_sample,
   output logic               o_valid
);

   import rx_pkg::*;

   iq_sample_t acc;
   iq_sample_t sum;

   // Running sum including the current sample
   always_comb
   begin
      sum.i = acc.i + i_sample.i;
      sum.q = acc.q + i_sample.q;
   end

   // Accumulators
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         acc <= '0;
      end
      else if (!i_enable)
      begin
         acc <= '0;
      end
      else if (i_strobe)
      begin
         // Restart the integration for the next output period
         acc <= '0;
      end
      else
      begin
         acc <= sum;
      end
   end

   // Dump register
   always_ff @(posedge clk64)
   begin
      if (i_enable && i_strobe)
      begin
         o_sample <= sum;
      end
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         o_valid <= 1'b0;
      end
      else
      begin
         o_valid <= i_enable && i_strobe;
      end
   end

endmodule

/* design/rx_pkg.sv */
// Shared definitions for the receive sample path
//   iq_sample_t   I/Q sample as carried on the ADC, loopback and output ports
//   rx_mode_t     Source selection flags held in the mode register
//   rx_rate_t     Decimation rate register payload
//   Serial settings bus widths and register addresses

package rx_pkg;

   // Serial settings bus
   localparam int SERIAL_ADDR_W = 7;
   localparam int SERIAL_DATA_W = 32;

   // Setting register addresses
   localparam logic [SERIAL_ADDR_W-1:0] FR_RX_MODE    = 7'd20;
   localparam logic [SERIAL_ADDR_W-1:0] FR_DECIM_RATE = 7'd21;

   // One complex sample, 32 bits in all
   typedef struct packed {
      logic signed [15:0] i;
      logic signed [15:0] q;
   } iq_sample_t;

   // Mode flags, counter takes priority over loopback
   // Bit 1 is counter and bit 0 is loopback
   typedef struct packed {
      logic counter;
      logic loopback;
   } rx_mode_t;

   // Decimation factor is rate+1
   typedef logic [7:0] rx_rate_t;

endpackage

/* design/rx_source_select.sv */
// Receive source selection
//   Debug counter, i = count and q = count+1, stepping by 2 per output
//   Loopback register captured from the transmit samples
//   Output mux with priority counter, then loopback, then decimated
//   Registered output sample and strobe, one cycle after the input valid

`timescale 1ns/1ps

module rx_source_select (
   input  logic               clk64,
   input  logic               rx_dsp_reset,
   input  logic               i_enable,
   input  rx_pkg::rx_mode_t   i_mode,
   input  logic               i_valid,
   input  rx_pkg::iq_sample_t i_sample,
   input  rx_pkg::iq_sample_t i_tx_sample,
   input  logic               i_tx_strobe,
   output rx_pkg::iq_sample_t o_rx_sample,
   output logic               o_rx_strobe
);

   import rx_pkg::*;

   logic [15:0] debug_counter;
   iq_sample_t  loopback;
   iq_sample_t  sel;

   // Debug counter restarts at zero whenever the receiver is off
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset || !i_enable)
      begin
         debug_counter <= 16'd0;
      end
      else if (i_valid)
      begin
         debug_counter <= debug_counter + 16'd2;
      end
   end

   // Last transmit sample seen
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         loopback <= '0;
      end
      else if (i_tx_strobe)
      begin
         loopback <= i_tx_sample;
      end
   end

   always_comb
   begin
      if (i_mode.counter)
      begin
         sel.i = signed'(debug_counter);
         sel.q = signed'(debug_counter + 16'd1);
      end
      else if (i_mode.loopback)
      begin
         sel = loopback;
      end
      else
      begin
         sel = i_sample;
      end
   end

   always_ff @(posedge clk64)
   begin
      if (i_valid)
      begin
         o_rx_sample <= sel;
      end
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         o_rx_strobe <= 1'b0;
      end
      else
      begin
         o_rx_strobe <= i_valid;
      end
   end

endmodule

/* design/rx_top.sv */
// Receive sample path top level
//   Mode and decimation rate setting registers on the serial settings bus
//   Decimation strobe generator and integrate-and-dump decimator
//   Source selection driving the 32-bit I/Q output and its strobe

`timescale 1ns/1ps

module rx_top (
   input  logic                              clk64,
   input  logic                              rx_dsp_reset,
   input  logic                              i_serial_strobe,
   input  logic [rx_pkg::SERIAL_ADDR_W-1:0]  i_serial_addr,
   input  logic [rx_pkg::SERIAL_DATA_W-1:0]  i_serial_data,
   input  logic                              i_enable_rx,
   input  rx_pkg::iq_sample_t                i_adc_sample,
   input  rx_pkg::iq_sample_t                i_tx_sample,
   input  logic                              i_tx_strobe,
   output rx_pkg::iq_sample_t                o_rx_sample,
   output logic                              o_rx_strobe
);

   import rx_pkg::*;

   rx_mode_t   mode;
   rx_rate_t   decim_rate;
   logic       strobe_decim;
   iq_sample_t decim_sample;
   logic       decim_valid;

   setting_reg #(.ADDR(FR_RX_MODE), .T(rx_mode_t)) sr_mode (
      .clk64           (clk64),
      .rx_dsp_reset    (rx_dsp_reset),
      .i_serial_strobe (i_serial_strobe),
      .i_serial_addr   (i_serial_addr),
      .i_serial_data   (i_serial_data),
      .o_value         (mode)
   );

   setting_reg #(.ADDR(FR_DECIM_RATE), .T(rx_rate_t)) sr_rate (
      .clk64           (clk64),
      .rx_dsp_reset    (rx_dsp_reset),
      .i_serial_strobe (i_serial_strobe),
      .i_serial_addr   (i_serial_addr),
      .i_serial_data   (i_serial_data),
      .o_value         (decim_rate)
   );

   decim_strobe_gen u_strobe_gen (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_enable     (i_enable_rx),
      .i_rate       (decim_rate),
      .o_strobe     (strobe_decim)
   );

   rx_decimator u_decimator (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_enable     (i_enable_rx),
      .i_strobe     (strobe_decim),
      .i_sample     (i_adc_sample),
      .o_sample     (decim_sample),
      .o_valid      (decim_valid)
   );

   rx_source_select u_source_select (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_enable     (i_enable_rx),
      .i_mode       (mode),
      .i_valid      (decim_valid),
      .i_sample     (decim_sample),
      .i_tx_sample  (i_tx_sample),
      .i_tx_strobe  (i_tx_strobe),
      .o_rx_sample  (o_rx_sample),
      .o_rx_strobe  (o_rx_strobe)
   );

endmodule

/* design/setting_reg.sv */
// Write-only setting register on the serial settings bus
//   Loads on a strobe whose address matches ADDR
//   Payload type and width come from the type parameter T

`timescale 1ns/1ps

module setting_reg #(
   parameter logic [rx_pkg::SERIAL_ADDR_W-1:0] ADDR = '0,
   parameter type T = logic [rx_pkg::SERIAL_DATA_W-1:0]
) (
   input  logic                              clk64,
   input  logic                              rx_dsp_reset,
   input  logic                              i_serial_strobe,
   input  logic [rx_pkg::SERIAL_ADDR_W-1:0]  i_serial_addr,
   input  logic [rx_pkg::SERIAL_DATA_W-1:0]  i_serial_data,
   output T                                  o_value
);

   // Payload is taken from the low bits of the data word
   localparam int VALUE_W = $bits(T);

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         o_value <= T'('0);
      end
      else if (i_serial_strobe && (i_serial_addr == ADDR))
      begin
         o_value <= T'(i_serial_data[VALUE_W-1:0]);
      end
   end

endmodule

/* testbench/tb_rx_tasks.svh */
// Testbench helper tasks for the receive sample path
//   check_value    compare two values and stop at the first mismatch
//   wait_outputs   wait for a number of output strobes with a timeout
//   idle_cycles    let a fixed number of clock cycles pass
//   serial_write   one write on the serial settings bus

`ifndef TB_RX_TASKS_SVH
`define TB_RX_TASKS_SVH

task automatic check_value(input string what, input logic [31:0] actual,
                           input logic [31:0] expected);
   if (actual !== expected)
   begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
   end
endtask

task automatic wait_outputs(input int n);
   int waited;
   waited = 0;
   while (out_count < n)
   begin
      @(posedge clk64);
      #1;
      waited = waited + 1;
      if (waited > 5000)
      begin
         $display("Timed out waiting for output strobes, saw %0d of %0d", out_count, n);
         $display("Simulation finished: FAIL");
         $fatal(1, "output strobe timeout");
      end
   end
endtask

task automatic idle_cycles(input int n);
   for (int k = 0; k < n; k++)
   begin
      @(posedge clk64);
      #1;
   end
endtask

// Strobe lasts one cycle from one step after a rising edge
task automatic serial_write(input logic [SERIAL_ADDR_W-1:0] addr,
                            input logic [SERIAL_DATA_W-1:0] data);
   i_serial_addr   = addr;
   i_serial_data   = data;
   i_serial_strobe = 1'b1;
   @(posedge clk64);
   #1;
   i_serial_strobe = 1'b0;
   // Data without a strobe must not load the register
   i_serial_data   = ~data;
endtask

`endif

/* testbench/tb_rx_top.sv */
// Testbench for the receive sample path top level
//   Clock, reset and stimulus on the settings bus, ADC and transmit inputs
//   Reference model for the expected output sample
//   Comparison process for output samples and strobe spacing
//   Test sequence for normal, counter, loopback and unrelated writes

`timescale 1ns/1ps

module tb_rx_top;

   import rx_pkg::*;

   logic                     clk64;
   logic                     rx_dsp_reset;
   logic                     i_serial_strobe;
   logic [SERIAL_ADDR_W-1:0] i_serial_addr;
   logic [SERIAL_DATA_W-1:0] i_serial_data;
   logic                     i_enable_rx;
   iq_sample_t               i_adc_sample;
   iq_sample_t               i_tx_sample;
   logic                     i_tx_strobe;
   iq_sample_t               o_rx_sample;
   logic                     o_rx_strobe;

   // Model state
   rx_mode_t   cur_mode;
   rx_rate_t   cur_rate;
   iq_sample_t adc_val;
   iq_sample_t last_tx;
   int         out_count;
   int         cycle_count;
   int         last_strobe_cycle;
   logic       first_output;
   integer     seed;
   logic [31:0] rnd;

   rx_top i_dut (
      .clk64           (clk64),
      .rx_dsp_reset    (rx_dsp_reset),
      .i_serial_strobe (i_serial_strobe),
      .i_serial_addr   (i_serial_addr),
      .i_serial_data   (i_serial_data),
      .i_enable_rx     (i_enable_rx),
      .i_adc_sample    (i_adc_sample),
      .i_tx_sample     (i_tx_sample),
      .i_tx_strobe     (i_tx_strobe),
      .o_rx_sample     (o_rx_sample),
      .o_rx_strobe     (o_rx_strobe)
   );

   `include "tb_rx_tasks.svh"

   always #5 clk64 = ~clk64;

   // Expected output number n of an enabled run
   function automatic iq_sample_t expected_sample(input rx_mode_t mode, input rx_rate_t rate,
                                                  input iq_sample_t adc, input iq_sample_t tx,
                                                  input int n);
      iq_sample_t  res;
      logic [15:0] factor;
      factor = {8'd0, rate} + 16'd1;
      if (mode.counter)
      begin
         res.i = 16'(2 * n);
         res.q = 16'(2 * n + 1);
      end
      else if (mode.loopback)
         res = tx;
      else
      begin
         // Boxcar of rate+1 equal samples wrapped to 16 bits
         res.i = adc.i * factor;
         res.q = adc.q * factor;
      end
      return res;
   endfunction

   always @(posedge clk64)
   begin
      cycle_count = cycle_count + 1;
      if (o_rx_strobe === 1'b1)
      begin
         if (!first_output)
            check_value("output strobe spacing", cycle_count - last_strobe_cycle,
                        {24'd0, cur_rate} + 32'd1);
         check_value("output sample", o_rx_sample,
                     expected_sample(cur_mode, cur_rate, adc_val, last_tx, out_count));
         first_output      = 1'b0;
         last_strobe_cycle = cycle_count;
         out_count         = out_count + 1;
      end
   end

   task automatic configure(input rx_mode_t mode, input rx_rate_t rate);
      serial_write(FR_DECIM_RATE, {24'd0, rate});
      serial_write(FR_RX_MODE, {30'd0, mode});
      cur_mode = mode;
      cur_rate = rate;
   endtask

   // One enabled run of n outputs, then disable and let the pipeline drain
   task automatic collect(input int n);
      idle_cycles(2);
      out_count    = 0;
      first_output = 1'b1;
      i_enable_rx  = 1'b1;
      wait_outputs(n);
      i_enable_rx  = 1'b0;
      idle_cycles(4);
   endtask

   task automatic new_adc_value;
      rnd          = $random(seed);
      adc_val      = rnd;
      i_adc_sample = rnd;
   endtask

   task automatic pulse_tx(input int n);
      for (int k = 0; k < n; k++)
      begin
         rnd         = $random(seed);
         i_tx_sample = rnd;
         last_tx     = rnd;
         i_tx_strobe = 1'b1;
         @(posedge clk64);
         #1;
         i_tx_strobe = 1'b0;
      end
      // Unstrobed data must not reach the loopback register
      i_tx_sample = ~last_tx;
   endtask

   task automatic expect_idle(input int n);
      for (int k = 0; k < n; k++)
      begin
         @(posedge clk64);
         #1;
         check_value("strobe while disabled", {31'd0, o_rx_strobe}, 32'd0);
      end
   endtask

   initial
   begin
      seed              = 32'hb892_8ea1;
      clk64             = 1'b0;
      rx_dsp_reset      = 1'b1;
      i_serial_strobe   = 1'b0;
      i_serial_addr     = '0;
      i_serial_data     = '0;
      i_enable_rx       = 1'b0;
      i_adc_sample      = '0;
      i_tx_sample       = '0;
      i_tx_strobe       = 1'b0;
      cur_mode          = '0;
      cur_rate          = '0;
      adc_val           = '0;
      last_tx           = '0;
      out_count         = 0;
      cycle_count       = 0;
      last_strobe_cycle = 0;
      first_output      = 1'b1;
      repeat (4) @(posedge clk64);
      #1;
      rx_dsp_reset = 1'b0;

      expect_idle(50);

      // Normal mode, spacing and boxcar sums
      new_adc_value();
      configure('{counter: 1'b0, loopback: 1'b0}, 8'd0);
      collect(8);
      new_adc_value();
      configure('{counter: 1'b0, loopback: 1'b0}, 8'd3);
      collect(8);
      new_adc_value();
      rnd = $random(seed);
      configure('{counter: 1'b0, loopback: 1'b0}, {4'd0, rnd[3:0]});
      collect(8);

      // Counter restarts at 0/1 after each re-enable
      configure('{counter: 1'b1, loopback: 1'b0}, 8'd3);
      collect(6);
      collect(6);

      // Loopback, then counter over loopback
      pulse_tx(5);
      configure('{counter: 1'b0, loopback: 1'b1}, 8'd2);
      collect(6);
      pulse_tx(3);
      collect(4);
      configure('{counter: 1'b1, loopback: 1'b1}, 8'd1);
      collect(5);

      // Unrelated addresses leave mode and rate alone
      configure('{counter: 1'b1, loopback: 1'b0}, 8'd5);
      rnd = $random(seed);
      serial_write(7'd22, rnd);
      serial_write(7'd19, ~rnd);
      collect(6);

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule
